//--- rtl/ctrlPkg.sv
package ctrlPkg;

  // Instruction field widths
  localparam int wordW   = 32;
  localparam int opcodeW = 6;
  localparam int functW  = 6;
  localparam int regIdxW = 5;
  localparam int aluOpW  = 4;

  typedef logic [wordW-1:0]   word_t;
  typedef logic [wordW-1:0]   instr_t;
  typedef logic [opcodeW-1:0] opcode_t;
  typedef logic [functW-1:0]  funct_t;
  typedef logic [regIdxW-1:0] regIdx_t;
  typedef logic [aluOpW-1:0]  aluOp_t;
  // Bit 3 is byte 0, big-endian lanes
  typedef logic [3:0]         byteEn_t;
  typedef logic [1:0]         sel2_t;

  // Primary opcodes
  localparam opcode_t opRtype = 6'h00;
  localparam opcode_t opJ     = 6'h02;
  localparam opcode_t opJal   = 6'h03;
  localparam opcode_t opBeq   = 6'h04;
  localparam opcode_t opBne   = 6'h05;
  localparam opcode_t opBlez  = 6'h06;
  localparam opcode_t opBgtz  = 6'h07;
  localparam opcode_t opAddiu = 6'h09;
  localparam opcode_t opSltiu = 6'h0B;
  localparam opcode_t opAndi  = 6'h0C;
  localparam opcode_t opOri   = 6'h0D;
  localparam opcode_t opXori  = 6'h0E;
  localparam opcode_t opLui   = 6'h0F;
  localparam opcode_t opLb    = 6'h20;
  localparam opcode_t opLh    = 6'h21;
  localparam opcode_t opLw    = 6'h23;
  localparam opcode_t opLbu   = 6'h24;
  localparam opcode_t opLhu   = 6'h25;
  localparam opcode_t opSb    = 6'h28;
  localparam opcode_t opSh    = 6'h29;
  localparam opcode_t opSw    = 6'h2B;

  // R-type function codes
  localparam funct_t fnSll  = 6'h00;
  localparam funct_t fnSrl  = 6'h02;
  localparam funct_t fnSra  = 6'h03;
  localparam funct_t fnJr   = 6'h08;
  localparam funct_t fnJalr = 6'h09;
  localparam funct_t fnAddu = 6'h21;
  localparam funct_t fnSubu = 6'h23;
  localparam funct_t fnAnd  = 6'h24;
  localparam funct_t fnOr   = 6'h25;
  localparam funct_t fnXor  = 6'h26;
  localparam funct_t fnNor  = 6'h27;
  localparam funct_t fnSlt  = 6'h2A;
  localparam funct_t fnSltu = 6'h2B;

  // ALU operations
  localparam aluOp_t aluAdd  = 4'd0;
  localparam aluOp_t aluSub  = 4'd1;
  localparam aluOp_t aluAnd  = 4'd2;
  localparam aluOp_t aluOr   = 4'd3;
  localparam aluOp_t aluXor  = 4'd4;
  localparam aluOp_t aluNor  = 4'd5;
  localparam aluOp_t aluSlt  = 4'd6;
  localparam aluOp_t aluSltu = 4'd7;
  localparam aluOp_t aluSll  = 4'd8;
  localparam aluOp_t aluSrl  = 4'd9;
  localparam aluOp_t aluSra  = 4'd10;
  localparam aluOp_t aluLui  = 4'd11;
  localparam aluOp_t aluXXX  = 4'd15;

  // Mux select codes
  localparam sel2_t pcNext   = 2'd0;
  localparam sel2_t pcBranch = 2'd1;
  localparam sel2_t pcReg    = 2'd2;
  localparam sel2_t pcJump   = 2'd3;

  localparam sel2_t dstRt   = 2'd0;
  localparam sel2_t dstRd   = 2'd1;
  localparam sel2_t dstRa   = 2'd2;
  localparam sel2_t dstNone = 2'd3;

  localparam sel2_t rdUart    = 2'd0;
  localparam sel2_t rdAlu     = 2'd1;
  localparam sel2_t rdDmem    = 2'd2;
  localparam sel2_t rdCounter = 2'd3;

  localparam sel2_t uartDataOut  = 2'd0;
  localparam sel2_t uartInReady  = 2'd1;
  localparam sel2_t uartOutValid = 2'd2;
  localparam sel2_t uartBios     = 2'd3;

  // selAlt is shamt on operand A, immediate on operand B
  localparam sel2_t selZero = 2'd0;
  localparam sel2_t selReg  = 2'd1;
  localparam sel2_t selFwd  = 2'd2;
  localparam sel2_t selAlt  = 2'd3;

  // Memory map
  localparam word_t addrUartInReady  = 32'h8000_0000;
  localparam word_t addrUartOutValid = 32'h8000_0004;
  localparam word_t addrUartTx       = 32'h8000_0008;
  localparam word_t addrUartRx       = 32'h8000_000C;
  localparam word_t addrCycleCount   = 32'h8000_0010;
  localparam word_t addrInstrCount   = 32'h8000_0014;
  localparam word_t addrCountReset   = 32'h8000_0018;
  localparam int         regionDmemBit = 0;
  localparam int         regionImemBit = 1;
  localparam logic [3:0] regionBios    = 4'h4;

  typedef struct packed {
    sel2_t aluSelA;
    sel2_t aluSelB;
    logic  dinSel;
  } fwdCtrl_t;

  typedef struct packed {
    logic  reUart;
    logic  weUart;
    logic  ctSel;
    logic  ctReset;
    logic  reDc;
    logic  iCacheSel;
    logic  weIm;
    logic  weDm;
    sel2_t uartSel;
  } ioCtrl_t;

  typedef struct packed {
    logic  regWrite;
    sel2_t regDst;
    sel2_t rdSel;
  } wbCtrl_t;

  // Field extraction
  function automatic opcode_t instrOp(instr_t i);
    return i[31:26];
  endfunction

  function automatic regIdx_t instrRs(instr_t i);
    return i[25:21];
  endfunction

  function automatic regIdx_t instrRt(instr_t i);
    return i[20:16];
  endfunction

  function automatic regIdx_t instrRd(instr_t i);
    return i[15:11];
  endfunction

  function automatic funct_t instrFunct(instr_t i);
    return i[5:0];
  endfunction

  // Opcode classes
  function automatic logic isImmOp(opcode_t op);
    return (op >= opAddiu) && (op <= opLui);
  endfunction

  function automatic logic isLoadOp(opcode_t op);
    return (op >= opLb) && (op <= opLhu);
  endfunction

  function automatic logic isStoreOp(opcode_t op);
    return (op == opSb) || (op == opSh) || (op == opSw);
  endfunction

endpackage

//--- rtl/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder
  import ctrlPkg::*;
(
  input  opcode_t opcode,
  input  funct_t  funct,
  output aluOp_t  aluOp
);

  aluOp_t rtypeOp;
  aluOp_t itypeOp;

  // R-type operations come from the function field
  always_comb begin
    case (funct)
      fnSll:   rtypeOp = aluSll;
      fnSrl:   rtypeOp = aluSrl;
      fnSra:   rtypeOp = aluSra;
      fnAddu:  rtypeOp = aluAdd;
      fnSubu:  rtypeOp = aluSub;
      fnAnd:   rtypeOp = aluAnd;
      fnOr:    rtypeOp = aluOr;
      fnXor:   rtypeOp = aluXor;
      fnNor:   rtypeOp = aluNor;
      fnSlt:   rtypeOp = aluSlt;
      fnSltu:  rtypeOp = aluSltu;
      default: rtypeOp = aluXXX;
    endcase
  end

  // Immediate arithmetic and logic
  always_comb begin
    case (opcode)
      opAddiu: itypeOp = aluAdd;
      opSltiu: itypeOp = aluSltu;
      opAndi:  itypeOp = aluAnd;
      opOri:   itypeOp = aluOr;
      opXori:  itypeOp = aluXor;
      opLui:   itypeOp = aluLui;
      default: itypeOp = aluXXX;
    endcase
  end

  always_comb begin
    if (opcode == opRtype) begin
      aluOp = rtypeOp;
    end else if (isImmOp(opcode)) begin
      aluOp = itypeOp;
    end else if (isLoadOp(opcode) || isStoreOp(opcode)) begin
      // Base plus offset
      aluOp = aluAdd;
    end else if ((opcode == opBeq) || (opcode == opBne) ||
                 (opcode == opBlez) || (opcode == opBgtz)) begin
      // Compare by subtraction
      aluOp = aluSub;
    end else begin
      aluOp = aluXXX;
    end
  end

endmodule

//--- rtl/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit
  import ctrlPkg::*;
(
  input  instr_t   instr,
  input  instr_t   prevInstr,
  output fwdCtrl_t fwd
);

  opcode_t op;
  opcode_t prevOp;
  funct_t  funct;
  regIdx_t rs;
  regIdx_t rt;
  regIdx_t prevDst;
  logic    prevDstValid;
  logic    matchA;
  logic    matchB;
  logic    isShift;
  logic    isLink;
  logic    usesImm;

  assign op     = instrOp(instr);
  assign prevOp = instrOp(prevInstr);
  assign funct  = instrFunct(instr);
  assign rs     = instrRs(instr);
  assign rt     = instrRt(instr);

  // Register written by the instruction one stage ahead
  always_comb begin
    if (prevOp == opRtype) begin
      prevDst = instrRd(prevInstr);
    end else if (isImmOp(prevOp) || isLoadOp(prevOp)) begin
      prevDst = instrRt(prevInstr);
    end else begin
      prevDst = '0;
    end
  end

  // r0 is hardwired to zero
  assign prevDstValid = (prevDst != '0);
  assign matchA       = prevDstValid && (rs == prevDst);
  assign matchB       = prevDstValid && (rt == prevDst);

  assign isShift = (op == opRtype) && (funct >= fnSll) && (funct <= fnSra);
  assign isLink  = (op == opJal) || ((op == opRtype) && (funct == fnJalr));
  assign usesImm = isImmOp(op) || isLoadOp(op) || isStoreOp(op);

  always_comb begin
    fwd.aluSelA = matchA ? selFwd : selReg;
    fwd.aluSelB = matchB ? selFwd : selReg;
    fwd.dinSel  = 1'b0;
    if (isLink) begin
      // Link address is built from zero operands
      fwd.aluSelA = selZero;
      fwd.aluSelB = selZero;
    end else if (isShift) begin
      fwd.aluSelA = selAlt;
    end else if (usesImm) begin
      fwd.aluSelB = selAlt;
      // Store data comes from rt, forward it separately
      fwd.dinSel  = matchB;
    end
  end

endmodule

//--- rtl/memMapDecoder.sv
`timescale 1ns/1ps

module memMapDecoder
  import ctrlPkg::*;
(
  input  word_t   address,
  input  word_t   pc,
  input  logic    memRead,
  input  logic    memWrite,
  output ioCtrl_t io,
  output sel2_t   rdSel
);

  logic [3:0] topNibble;
  logic       inDmem;
  logic       inImem;
  logic       inBios;
  logic       isCounterRd;
  logic       pcInBios;

  assign topNibble = address[31:28];

  // Region decode on the top address nibble
  assign inDmem = (topNibble[3:2] == 2'b00) && topNibble[regionDmemBit];
  assign inImem = (topNibble == (4'b0001 << regionImemBit));
  assign inBios = (topNibble == regionBios);

  // IMEM is only writable while running from BIOS space
  assign pcInBios = pc[30];

  assign isCounterRd = memRead &&
                       ((address == addrCycleCount) || (address == addrInstrCount));

  always_comb begin
    io         = '0;
    io.uartSel = uartDataOut;
    rdSel      = rdAlu;

    // Data memory through the data cache
    if (memWrite && inDmem) begin
      io.weDm = 1'b1;
    end
    if (memRead && inDmem) begin
      io.reDc = 1'b1;
      rdSel   = rdDmem;
    end

    // Instruction memory writes
    if (memWrite && inImem && pcInBios) begin
      io.weIm      = 1'b1;
      io.iCacheSel = 1'b1;
    end

    // Cycle and instruction counters
    if (isCounterRd) begin
      io.ctSel = (address == addrInstrCount);
      rdSel    = rdCounter;
    end
    if (memWrite && (address == addrCountReset)) begin
      io.ctReset = 1'b1;
    end

    // UART transmit
    if (memWrite && (address == addrUartTx)) begin
      io.weUart = 1'b1;
    end

    // UART status, receive data and BIOS reads share one read port
    if (memRead) begin
      if (address == addrUartInReady) begin
        io.uartSel = uartInReady;
        rdSel      = rdUart;
      end else if (address == addrUartOutValid) begin
        io.uartSel = uartOutValid;
        rdSel      = rdUart;
      end else if (address == addrUartRx) begin
        io.reUart  = 1'b1;
        io.uartSel = uartDataOut;
        rdSel      = rdUart;
      end else if (inBios) begin
        io.uartSel = uartBios;
        rdSel      = rdUart;
      end
    end
  end

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  instr_t     instr,
  input  word_t      address,
  input  word_t      pc,
  input  logic       branch,
  input  logic [1:0] offset,
  output aluOp_t     aluOp,
  output sel2_t      pcSel,
  output wbCtrl_t    wb,
  output fwdCtrl_t   fwd,
  output ioCtrl_t    io,
  output byteEn_t    imByteEn,
  output byteEn_t    dmByteEn
);

  instr_t   prevInstr;
  opcode_t  op;
  funct_t   funct;
  logic     isRtype;
  logic     memRead;
  logic     memWrite;
  logic     regWrite;
  sel2_t    regDst;
  sel2_t    rdSel;
  sel2_t    pcSelRaw;
  byteEn_t  byteEn;
  fwdCtrl_t fwdRaw;
  ioCtrl_t  ioRaw;

  // Instruction history for forwarding
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevInstr <= '0;
    end else begin
      prevInstr <= instr;
    end
  end

  assign op      = instrOp(instr);
  assign funct   = instrFunct(instr);
  assign isRtype = (op == opRtype);

  assign memRead  = isLoadOp(op);
  assign memWrite = isStoreOp(op);

  // Register write-back
  assign regWrite = (isRtype && (funct != fnJr)) || isImmOp(op) ||
                    isLoadOp(op) || (op == opJal);

  always_comb begin
    if (isRtype) begin
      regDst = dstRd;
    end else if (isImmOp(op) || isLoadOp(op)) begin
      regDst = dstRt;
    end else if (op == opJal) begin
      regDst = dstRa;
    end else begin
      regDst = dstNone;
    end
  end

  // Next PC, branch strobe wins
  always_comb begin
    if (branch) begin
      pcSelRaw = pcBranch;
    end else if ((op == opJ) || (op == opJal)) begin
      pcSelRaw = pcJump;
    end else if (isRtype && ((funct == fnJr) || (funct == fnJalr))) begin
      pcSelRaw = pcReg;
    end else begin
      pcSelRaw = pcNext;
    end
  end

  // Store byte lanes
  always_comb begin
    case (op)
      opSb:    byteEn = 4'b1000 >> offset;
      opSh:    byteEn = 4'b1100 >> {offset[1], 1'b0};
      opSw:    byteEn = 4'b1111;
      default: byteEn = 4'b0000;
    endcase
  end

  aluDecoder i_aluDecoder (
    .opcode (op),
    .funct  (funct),
    .aluOp  (aluOp)
  );

  forwardUnit i_forwardUnit (
    .instr     (instr),
    .prevInstr (prevInstr),
    .fwd       (fwdRaw)
  );

  memMapDecoder i_memMapDecoder (
    .address  (address),
    .pc       (pc),
    .memRead  (memRead),
    .memWrite (memWrite),
    .io       (ioRaw),
    .rdSel    (rdSel)
  );

  // Hold every control inactive during reset
  assign pcSel = arstN ? pcSelRaw : pcNext;
  assign fwd   = arstN ? fwdRaw : '0;
  assign io    = arstN ? ioRaw : '0;
  assign wb    = arstN ? '{regWrite: regWrite, regDst: regDst, rdSel: rdSel} : '0;

  // Lanes only reach the memory being written
  assign imByteEn = io.weIm ? byteEn : '0;
  assign dmByteEn = io.weDm ? byteEn : '0;

endmodule

//--- verif/controlUnit_chk.sv
`timescale 1ns/1ps

module controlUnitChk
  import ctrlPkg::*;
(
  input logic     clk,
  input logic     arstN,
  input sel2_t    pcSel,
  input wbCtrl_t  wb,
  input fwdCtrl_t fwd,
  input ioCtrl_t  io,
  input byteEn_t  imByteEn,
  input byteEn_t  dmByteEn
);

  // UART read and write never in the same cycle
  uartExclusive: assert property (@(posedge clk) disable iff (!arstN)
    !(io.weUart && io.reUart))
    else $error("UART read and write strobes set together");

  imemLanes: assert property (@(posedge clk) disable iff (!arstN)
    !io.weIm |-> (imByteEn == '0))
    else $error("Instruction memory byte enables without a write");

  dmemLanes: assert property (@(posedge clk) disable iff (!arstN)
    !io.weDm |-> (dmByteEn == '0))
    else $error("Data memory byte enables without a write");

  // Everything idle in reset
  resetIdle: assert property (@(posedge clk)
    !arstN |-> ((pcSel == pcNext) && (wb == '0) && (fwd == '0) && (io == '0) &&
                (imByteEn == '0) && (dmByteEn == '0)))
    else $error("Control output active during reset");

endmodule

bind controlUnit controlUnitChk i_chk (
  .clk      (clk),
  .arstN    (arstN),
  .pcSel    (pcSel),
  .wb       (wb),
  .fwd      (fwd),
  .io       (io),
  .imByteEn (imByteEn),
  .dmByteEn (dmByteEn)
);

//--- verif/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb
  import ctrlPkg::*;
();

  localparam int clkPeriod   = 40;
  localparam int numDirected = 128;
  localparam int numRandom   = 300;

  // Legal instructions and the ALU operation each one selects
  localparam logic [15:0] instrTab [33] = '{
    {opRtype, fnSll, aluSll},   {opRtype, fnSrl, aluSrl},   {opRtype, fnSra, aluSra},
    {opRtype, fnJr, aluXXX},    {opRtype, fnJalr, aluXXX},  {opRtype, fnAddu, aluAdd},
    {opRtype, fnSubu, aluSub},  {opRtype, fnAnd, aluAnd},   {opRtype, fnOr, aluOr},
    {opRtype, fnXor, aluXor},   {opRtype, fnNor, aluNor},   {opRtype, fnSlt, aluSlt},
    {opRtype, fnSltu, aluSltu}, {opAddiu, 6'h00, aluAdd},   {opSltiu, 6'h00, aluSltu},
    {opAndi, 6'h00, aluAnd},    {opOri, 6'h00, aluOr},      {opXori, 6'h00, aluXor},
    {opLui, 6'h00, aluLui},     {opJ, 6'h00, aluXXX},       {opJal, 6'h00, aluXXX},
    {opBeq, 6'h00, aluSub},     {opBne, 6'h00, aluSub},     {opBlez, 6'h00, aluSub},
    {opBgtz, 6'h00, aluSub},    {opLb, 6'h00, aluAdd},      {opLh, 6'h00, aluAdd},
    {opLw, 6'h00, aluAdd},      {opLbu, 6'h00, aluAdd},     {opLhu, 6'h00, aluAdd},
    {opSb, 6'h00, aluAdd},      {opSh, 6'h00, aluAdd},      {opSw, 6'h00, aluAdd}
  };

  // Memory map registers plus one address in each region
  localparam word_t addrTab [12] = '{
    addrUartInReady, addrUartOutValid, addrUartTx, addrUartRx,
    addrCycleCount, addrInstrCount, addrCountReset, 32'h1000_0010,
    32'h3000_0020, 32'h2000_0040, 32'h4000_0100, 32'h0000_1000
  };

  localparam opcode_t storeOps [3] = '{opSb, opSh, opSw};

  typedef struct packed {
    aluOp_t   aluOp;
    sel2_t    pcSel;
    wbCtrl_t  wb;
    fwdCtrl_t fwd;
    ioCtrl_t  io;
    byteEn_t  imByteEn;
    byteEn_t  dmByteEn;
  } outSet_t;

  logic       clk;
  logic       arstN;
  instr_t     instr;
  word_t      address;
  word_t      pc;
  logic       branch;
  logic [1:0] offset;
  aluOp_t     aluOp;
  sel2_t      pcSel;
  wbCtrl_t    wb;
  fwdCtrl_t   fwd;
  ioCtrl_t    io;
  byteEn_t    imByteEn;
  byteEn_t    dmByteEn;
  instr_t     prevModel;
  outSet_t    expected;
  int         errors;
  int         checks;

  controlUnit i_dut (
    .clk      (clk),
    .arstN    (arstN),
    .instr    (instr),
    .address  (address),
    .pc       (pc),
    .branch   (branch),
    .offset   (offset),
    .aluOp    (aluOp),
    .pcSel    (pcSel),
    .wb       (wb),
    .fwd      (fwd),
    .io       (io),
    .imByteEn (imByteEn),
    .dmByteEn (dmByteEn)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // Previous instruction as the pipeline sees it
  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevModel <= '0;
    end else begin
      prevModel <= instr;
    end
  end

  function automatic logic inImmRange(opcode_t op);
    return (op >= opAddiu) && (op <= opLui);
  endfunction

  function automatic logic inLoadRange(opcode_t op);
    return (op >= opLb) && (op <= opLhu);
  endfunction

  function automatic instr_t makeR(funct_t fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
    return {opRtype, rs, rt, rd, 5'd2, fn};
  endfunction

  function automatic instr_t makeI(opcode_t op, regIdx_t rs, regIdx_t rt);
    return {op, rs, rt, 16'h0040};
  endfunction

  // Expected outputs for one cycle
  function automatic outSet_t expectOut(instr_t i, instr_t p, word_t a, word_t pcv,
                                        logic br, logic [1:0] off, logic rstN);
    outSet_t e;
    opcode_t op;
    funct_t  fn;
    regIdx_t pDst;
    logic    isR;
    logic    isLd;
    logic    isSt;
    logic    inDmem;
    logic    matchA;
    logic    matchB;
    byteEn_t lanes;
    op   = i[31:26];
    fn   = i[5:0];
    isR  = (op == opRtype);
    isLd = inLoadRange(op);
    isSt = (op == opSb) || (op == opSh) || (op == opSw);
    e    = '0;
    e.aluOp = aluXXX;
    foreach (instrTab[k]) begin
      if ((instrTab[k][15:10] == op) && (!isR || (instrTab[k][9:4] == fn))) begin
        e.aluOp = instrTab[k][3:0];
      end
    end
    e.wb.regWrite = (isR && (fn != fnJr)) || inImmRange(op) || isLd || (op == opJal);
    e.wb.regDst   = isR ? dstRd : (inImmRange(op) || isLd) ? dstRt :
                    (op == opJal) ? dstRa : dstNone;
    e.pcSel = br ? pcBranch : ((op == opJ) || (op == opJal)) ? pcJump :
              (isR && ((fn == fnJr) || (fn == fnJalr))) ? pcReg : pcNext;
    // Destination of the instruction one stage ahead
    pDst = (p[31:26] == opRtype) ? p[15:11] :
           (inImmRange(p[31:26]) || inLoadRange(p[31:26])) ? p[20:16] : 5'd0;
    matchA = (pDst != 5'd0) && (i[25:21] == pDst);
    matchB = (pDst != 5'd0) && (i[20:16] == pDst);
    e.fwd.aluSelA = matchA ? selFwd : selReg;
    e.fwd.aluSelB = matchB ? selFwd : selReg;
    if ((op == opJal) || (isR && (fn == fnJalr))) begin
      e.fwd.aluSelA = selZero;
      e.fwd.aluSelB = selZero;
    end else if (isR && (fn <= fnSra)) begin
      e.fwd.aluSelA = selAlt;
    end else if (inImmRange(op) || isLd || isSt) begin
      e.fwd.aluSelB = selAlt;
      e.fwd.dinSel  = matchB;
    end
    // Memory map
    inDmem     = (a[31:30] == 2'b00) && a[28];
    e.wb.rdSel = (isLd && inDmem) ? rdDmem : rdAlu;
    e.io.weDm  = isSt && inDmem;
    e.io.reDc  = isLd && inDmem;
    e.io.weIm      = isSt && (a[31:28] == 4'h2) && pcv[30];
    e.io.iCacheSel = e.io.weIm;
    if (isLd && ((a == addrCycleCount) || (a == addrInstrCount))) begin
      e.io.ctSel = (a == addrInstrCount);
      e.wb.rdSel = rdCounter;
    end
    e.io.ctReset = isSt && (a == addrCountReset);
    e.io.weUart  = isSt && (a == addrUartTx);
    e.io.reUart  = isLd && (a == addrUartRx);
    if (isLd && ((a == addrUartInReady) || (a == addrUartOutValid) || e.io.reUart ||
                 (a[31:28] == regionBios))) begin
      e.wb.rdSel   = rdUart;
      e.io.uartSel = (a == addrUartInReady) ? uartInReady :
                     (a == addrUartOutValid) ? uartOutValid :
                     e.io.reUart ? uartDataOut : uartBios;
    end
    case (op)
      opSb:    lanes = 4'b1000 >> off;
      opSh:    lanes = off[1] ? 4'b0011 : 4'b1100;
      opSw:    lanes = 4'b1111;
      default: lanes = 4'b0000;
    endcase
    e.imByteEn = e.io.weIm ? lanes : 4'b0000;
    e.dmByteEn = e.io.weDm ? lanes : 4'b0000;
    // ALU decode is not gated by reset
    if (!rstN) begin
      e.pcSel    = pcNext;
      e.wb       = '0;
      e.fwd      = '0;
      e.io       = '0;
      e.imByteEn = '0;
      e.dmByteEn = '0;
    end
    return e;
  endfunction

  task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic applyVec(input instr_t i, input word_t a, input word_t p, input logic br,
                          input logic [1:0] off);
    @(posedge clk);
    #2;
    instr   = i;
    address = a;
    pc      = p;
    branch  = br;
    offset  = off;
  endtask

  // Outputs settle well before the late sample point
  always @(posedge clk) begin
    #30;
    expected = expectOut(instr, prevModel, address, pc, branch, offset, arstN);
    checkField("aluOp", 32'(expected.aluOp), 32'(aluOp));
    checkField("pcSel", 32'(expected.pcSel), 32'(pcSel));
    checkField("wb.regWrite", 32'(expected.wb.regWrite), 32'(wb.regWrite));
    checkField("wb.regDst", 32'(expected.wb.regDst), 32'(wb.regDst));
    checkField("wb.rdSel", 32'(expected.wb.rdSel), 32'(wb.rdSel));
    checkField("fwd.aluSelA", 32'(expected.fwd.aluSelA), 32'(fwd.aluSelA));
    checkField("fwd.aluSelB", 32'(expected.fwd.aluSelB), 32'(fwd.aluSelB));
    checkField("fwd.dinSel", 32'(expected.fwd.dinSel), 32'(fwd.dinSel));
    checkField("io.reUart", 32'(expected.io.reUart), 32'(io.reUart));
    checkField("io.weUart", 32'(expected.io.weUart), 32'(io.weUart));
    checkField("io.ctSel", 32'(expected.io.ctSel), 32'(io.ctSel));
    checkField("io.ctReset", 32'(expected.io.ctReset), 32'(io.ctReset));
    checkField("io.reDc", 32'(expected.io.reDc), 32'(io.reDc));
    checkField("io.iCacheSel", 32'(expected.io.iCacheSel), 32'(io.iCacheSel));
    checkField("io.weIm", 32'(expected.io.weIm), 32'(io.weIm));
    checkField("io.weDm", 32'(expected.io.weDm), 32'(io.weDm));
    checkField("io.uartSel", 32'(expected.io.uartSel), 32'(io.uartSel));
    checkField("imByteEn", 32'(expected.imByteEn), 32'(imByteEn));
    checkField("dmByteEn", 32'(expected.dmByteEn), 32'(dmByteEn));
  end

  initial begin
    #((numDirected + numRandom + 10) * clkPeriod);
    $display("Timeout, the stimulus did not complete in the expected run time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int     k;
    instr_t ri;
    word_t  ra;
    void'($urandom(32'h69064bd5));
    errors  = 0;
    checks  = 0;
    clk     = 1'b0;
    arstN   = 1'b0;
    // Store to data memory with a branch, all of it masked by reset
    instr   = makeI(opSw, 5'd1, 5'd2);
    address = 32'h1000_0004;
    pc      = 32'h4000_0000;
    branch  = 1'b1;
    offset  = 2'd0;
    @(posedge clk);
    #2;
    // Load into r4 that the cleared history never sees
    instr   = makeI(opLw, 5'd1, 5'd4);
    @(posedge clk);
    #2;
    arstN   = 1'b1;
    // Reads r4 with an empty history
    instr   = makeR(fnAddu, 5'd4, 5'd4, 5'd3);
    branch  = 1'b0;

    // Every table entry once
    for (int n = 0; n < 33; n++) begin
      applyVec({instrTab[n][15:10], 5'd1, 5'd2, 5'd3, 5'd0, instrTab[n][9:4]},
               32'h1000_0000 + 32'(n * 4), 32'h0, 1'b0, 2'd0);
    end

    // Dependent pairs
    applyVec(makeR(fnAddu, 5'd1, 5'd2, 5'd5), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeR(fnSubu, 5'd5, 5'd5, 5'd6), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeI(opAddiu, 5'd6, 5'd7), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeI(opSw, 5'd0, 5'd7), 32'h1000_0000, 32'h0, 1'b0, 2'd0);
    applyVec(makeI(opLw, 5'd7, 5'd8), 32'h1000_0000, 32'h0, 1'b0, 2'd0);
    applyVec(makeR(fnSll, 5'd0, 5'd8, 5'd9), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeR(fnJalr, 5'd9, 5'd0, 5'd31), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeI(opAddiu, 5'd0, 5'd0), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeR(fnAddu, 5'd0, 5'd0, 5'd1), 32'h0, 32'h0, 1'b0, 2'd0);
    applyVec(makeI(opJal, 5'd1, 5'd1), 32'h0, 32'h0, 1'b0, 2'd0);

    // PC select priority
    for (int b = 0; b < 2; b++) begin
      applyVec(makeI(opBeq, 5'd1, 5'd2), 32'h0, 32'h0, b[0], 2'd0);
      applyVec(makeI(opJ, 5'd0, 5'd0), 32'h0, 32'h0, b[0], 2'd0);
      applyVec(makeI(opJal, 5'd0, 5'd0), 32'h0, 32'h0, b[0], 2'd0);
      applyVec(makeR(fnJr, 5'd4, 5'd0, 5'd0), 32'h0, 32'h0, b[0], 2'd0);
      applyVec(makeR(fnJalr, 5'd4, 5'd0, 5'd31), 32'h0, 32'h0, b[0], 2'd0);
      applyVec(makeR(fnAddu, 5'd4, 5'd5, 5'd6), 32'h0, 32'h0, b[0], 2'd0);
    end

    // Loads and stores over the memory map, pc inside and outside BIOS
    for (int a = 0; a < 12; a++) begin
      for (int st = 0; st < 2; st++) begin
        for (int pb = 0; pb < 2; pb++) begin
          applyVec(makeI((st == 1) ? opSw : opLw, 5'd1, 5'd2), addrTab[a],
                   (pb == 1) ? 32'h4000_0000 : 32'h0000_0400, 1'b0, 2'd0);
        end
      end
    end

    // Byte lanes at every offset into both memories
    for (int s = 0; s < 3; s++) begin
      for (int off = 0; off < 4; off++) begin
        applyVec(makeI(storeOps[s], 5'd1, 5'd2), 32'h1000_0000, 32'h4000_0000, 1'b0, 2'(off));
        applyVec(makeI(storeOps[s], 5'd1, 5'd2), 32'h2000_0000, 32'h4000_0000, 1'b0, 2'(off));
      end
    end

    // Random mix, small register range so dependencies are common
    for (int n = 0; n < numRandom; n++) begin
      k  = $urandom % 33;
      ri = {instrTab[k][15:10], 5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8),
            5'($urandom), 6'($urandom)};
      if (instrTab[k][15:10] == opRtype) begin
        ri[5:0] = instrTab[k][9:4];
      end
      case ($urandom % 3)
        0:       ra = addrTab[$urandom % 12];
        1:       ra = {4'($urandom % 4 + 1), 28'($urandom)};
        default: ra = $urandom;
      endcase
      applyVec(ri, ra, $urandom, ($urandom % 4) == 0, 2'($urandom));
    end

    #40;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
rtl/ctrlPkg.sv
rtl/aluDecoder.sv
rtl/forwardUnit.sv
rtl/memMapDecoder.sv
rtl/controlUnit.sv
verif/controlUnit_chk.sv
verif/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the controlUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module controlUnitTb \
  -f list.f -o simv > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
